// File: ll_tracker_top.f
+incdir+src
+incdir+sim
src/ll_tracker_pkg.sv
src/ll_tail_steer.sv
src/ll_ptr_ram.sv
src/ll_head_ctrl.sv
src/ll_tracker_top.sv
sim/ll_tracker_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the linked-list tracker testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary \
  --top-module ll_tracker_tb \
  -f ll_tracker_top.f \
  -o ll_tracker_sim

# The simulator may exit with an error on a failing check, so the log decides.
./obj_dir/ll_tracker_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
  echo "Simulation passed."
  exit 0
else
  echo "Simulation failed."
  exit 1
fi

// File: sim/ll_tracker_checks.svh
// Linked-list tracker testbench reference model and value compare helpers.
`ifndef LL_TRACKER_CHECKS_SVH
`define LL_TRACKER_CHECKS_SVH

// Pushed addresses in arrival order. Round-robin push and pop over the
// lists make this the order in which heads must leave.
addr_t expected_q[$];

function automatic void record_push(input addr_t addr);
  expected_q.push_back(addr);
endfunction

// Oldest entry still tracked, which is the head the DUT has to present.
function automatic addr_t expected_head();
  return expected_q[0];
endfunction

function automatic void retire_head();
  void'(expected_q.pop_front());
endfunction

// Entries pushed minus entries popped at earlier edges.
function automatic int expected_items();
  return expected_q.size();
endfunction

task automatic abort_run(input string reason);
  $display("%s", reason);
  $display("Done: errors found");
  $fatal(1, "simulation stopped");
endtask

task automatic check_value(input string name, input int expected, input int actual);
  string line;
  if (expected != actual) begin
    line = $sformatf("ERROR %s: expected %0d, actual %0d", name, expected, actual);
    abort_run(line);
  end
endtask

`endif

// File: sim/ll_tracker_tb.sv
// Linked-list tracker testbench with random and directed traffic against an in-order model.
`timescale 1ns/1ns
`include "ll_tracker_config.svh"

module ll_tracker_tb
  import ll_tracker_pkg::*;
;

  localparam int CLK_PERIOD       = 8;
  localparam int RESET_CYCLES     = 10;
  localparam int RAND_CYCLES      = 3000;
  localparam int BYPASS_POPS      = 3 * `LL_DEPTH;
  localparam int NUM_TRANS        = RAND_CYCLES + BYPASS_POPS + 4 * `LL_DEPTH + 16;
  localparam int ITEM_CYCLE_BOUND = 6;
  localparam int WATCHDOG_CYCLES  = RESET_CYCLES + NUM_TRANS * ITEM_CYCLE_BOUND;

  logic   clk;
  logic   arst_n;
  logic   next_tail_valid;
  addr_t  next_tail;
  logic   head_valid;
  logic   head_ready;
  addr_t  head;
  logic   empty;
  count_t items;

  // Addresses that are not tracked and may be pushed.
  addr_t free_pool[$];
  bit    checking = 1'b0;

  `include "ll_tracker_checks.svh"

  ll_tracker_top uut (
    .clk             (clk),
    .arst_n          (arst_n),
    .next_tail_valid (next_tail_valid),
    .next_tail       (next_tail),
    .head_valid      (head_valid),
    .head_ready      (head_ready),
    .head            (head),
    .empty           (empty),
    .items           (items)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Drives one cycle of inputs from the falling edge and waits for the next one.
  task automatic drive_step(input bit want_push, input bit ready);
    int idx;
    next_tail_valid = 1'b0;
    head_ready      = ready;
    if (want_push && free_pool.size() > 0) begin
      idx = int'($urandom % free_pool.size());
      next_tail       = free_pool[idx];
      free_pool.delete(idx);
      next_tail_valid = 1'b1;
    end
    @(negedge clk);
  endtask

  // Stimulus.
  initial begin : stimulus
    int pops;
    bit push_now;
    void'($urandom(32'h3367_05ea));
    arst_n          = 1'b0;
    next_tail_valid = 1'b0;
    next_tail       = '0;
    head_ready      = 1'b0;
    for (int a = 0; a < `LL_DEPTH; a++) begin
      free_pool.push_back(addr_t'(a));
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    check_value("reset head_valid", 0, int'(head_valid));
    check_value("reset empty", 1, int'(empty));
    check_value("reset items", 0, int'(items));
    arst_n   = 1'b1;
    checking = 1'b1;

    // One push into an empty list, then a single pop.
    drive_step(1'b1, 1'b0);
    while (!head_valid) drive_step(1'b0, 1'b0);
    drive_step(1'b0, 1'b1);
    drive_step(1'b0, 1'b0);

    // Random pushes with randomly stalled pops.
    repeat (RAND_CYCLES) begin
      drive_step($urandom_range(99) < 55, $urandom_range(99) < 50);
    end
    while (free_pool.size() != `LL_DEPTH) drive_step(1'b0, 1'b1);

    // Fill up, then drain and refill a list in the cycle its last item leaves.
    while (free_pool.size() > 0) drive_step(1'b1, 1'b0);
    pops = 0;
    while (pops < BYPASS_POPS) begin
      push_now = head_valid && (`LL_DEPTH - free_pool.size() <= `LL_NUM_LISTS);
      if (head_valid) pops++;
      drive_step(push_now, 1'b1);
    end
    while (free_pool.size() != `LL_DEPTH) drive_step(1'b0, 1'b1);

    repeat (4) drive_step(1'b0, 1'b0);
    check_value("final items", 0, int'(items));
    $display("Done: no errors");
    $finish;
  end

  // Samples between the falling and the rising edge, where inputs and outputs are stable.
  initial begin : compare
    bit    stall_seen;
    addr_t stall_head;
    stall_seen = 1'b0;
    stall_head = '0;
    forever begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      if (checking) begin
        check_value("items", expected_items(), int'(items));
        check_value("empty", int'(expected_items() == 0), int'(empty));
        if (expected_items() == 0) begin
          check_value("idle head_valid", 0, int'(head_valid));
        end
        // A stalled head must stay valid and unchanged.
        if (stall_seen) begin
          check_value("stalled head_valid", 1, int'(head_valid));
          check_value("stalled head", int'(stall_head), int'(head));
        end
        if (head_valid && head_ready) begin
          check_value("head order", int'(expected_head()), int'(head));
          free_pool.push_back(expected_head());
          retire_head();
        end
        if (next_tail_valid) begin
          record_push(next_tail);
        end
        stall_seen = head_valid && !head_ready;
        stall_head = head;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("Timeout: the run did not finish within its cycle bound.");
  end

endmodule

// File: src/ll_head_ctrl.sv
// Head stage that keeps per-list counts and heads, presents the oldest entry and refills from RAM.
`timescale 1ns/1ns
`include "ll_tracker_config.svh"

module ll_head_ctrl
  import ll_tracker_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      push_valid,
  input  list_sel_t push_sel,
  input  addr_t     push_addr,
  output logic      head_valid,
  input  logic      head_ready,
  output addr_t     head,
  output list_sel_t list_empty,
  output logic      ptr_rd_valid,
  output addr_t     ptr_rd_addr,
  input  logic      ptr_rd_data_valid,
  input  addr_t     ptr_rd_data,
  output logic      empty,
  output count_t    items
);

  list_sel_t head_sel;
  list_sel_t head_sel_next;
  list_sel_t head_sel_rd;
  list_sel_t list_empty_next;
  list_sel_t head_last;
  list_sel_t head_bypass;
  list_sel_t head_load_push;
  list_sel_t head_load_ram;
  list_sel_t head_vld;
  list_sel_t head_vld_next;
  list_sel_t list_incr;
  list_sel_t list_decr;
  count_t    count_q [`LL_NUM_LISTS];
  count_t    count_next [`LL_NUM_LISTS];
  addr_t     head_q [`LL_NUM_LISTS];
  logic      pop;

  assign pop = head_valid && head_ready;

  // Head selector rotates by one list per pop, mirroring the tail side.
  always_comb begin
    for (int i = 0; i < `LL_NUM_LISTS; i++) begin
      head_sel_next[i] = head_sel[(i + `LL_NUM_LISTS - 1) % `LL_NUM_LISTS];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head_sel <= list_sel_t'(1);
    end else if (pop) begin
      head_sel <= head_sel_next;
    end
  end

  // Remember which list issued the RAM read. By the time the data returns
  // the live selector has already moved on to the next list.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head_sel_rd <= '0;
    end else if (ptr_rd_valid) begin
      head_sel_rd <= head_sel;
    end
  end

  // Per-list bookkeeping.
  always_comb begin
    for (int i = 0; i < `LL_NUM_LISTS; i++) begin
      list_incr[i]       = push_valid && push_sel[i];
      list_decr[i]       = pop && head_sel[i];
      count_next[i]      = count_q[i] + count_t'(list_incr[i]) - count_t'(list_decr[i]);
      list_empty_next[i] = (count_next[i] == '0);
      head_last[i]       = (count_q[i] == count_t'(1));

      // The pushed address goes straight to the head when there is nothing
      // ahead of it: the list is empty, or its only item leaves this cycle.
      head_bypass[i] = list_empty[i] ||
                       (head_last[i] && head_vld[i] && head_sel[i] && head_ready);

      head_load_push[i] = list_incr[i] && head_bypass[i];
      head_load_ram[i]  = ptr_rd_data_valid && head_sel_rd[i];

      // A popped head is invalid until it is reloaded.
      head_vld_next[i] = (head_vld[i] && !list_decr[i]) ||
                         head_load_push[i] || head_load_ram[i];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `LL_NUM_LISTS; i++) begin
        count_q[i] <= '0;
      end
      list_empty <= '1;
      head_vld   <= '0;
    end else begin
      for (int i = 0; i < `LL_NUM_LISTS; i++) begin
        count_q[i] <= count_next[i];
      end
      list_empty <= list_empty_next;
      head_vld   <= head_vld_next;
    end
  end

  // Head addresses. The push path wins if both sources could load,
  // which the list protocol rules out anyway.
  always_ff @(posedge clk) begin
    for (int i = 0; i < `LL_NUM_LISTS; i++) begin
      if (head_load_push[i]) begin
        head_q[i] <= push_addr;
      end else if (head_load_ram[i]) begin
        head_q[i] <= ptr_rd_data;
      end
    end
  end

  assign head_valid = |(head_sel & ~list_empty & head_vld);

  always_comb begin
    head = '0;
    for (int i = 0; i < `LL_NUM_LISTS; i++) begin
      head = head | ({`LL_ADDR_W{head_sel[i]}} & head_q[i]);
    end
  end

  // A popped head's link is fetched unless it was the last one in its list.
  assign ptr_rd_valid = pop && |(head_sel & ~head_last);
  assign ptr_rd_addr  = head;

  assign empty = &list_empty;

  // Total number of tracked entries.
  always_comb begin
    items = '0;
    for (int i = 0; i < `LL_NUM_LISTS; i++) begin
      items = items + count_q[i];
    end
  end

endmodule

// File: src/ll_ptr_ram.sv
// Pointer RAM holding next-entry links, one write port and a one-cycle read port.
`timescale 1ns/1ns
`include "ll_tracker_config.svh"

module ll_ptr_ram
  import ll_tracker_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  ptr_wr_valid,
  input  addr_t ptr_wr_addr,
  input  addr_t ptr_wr_data,
  input  logic  ptr_rd_valid,
  input  addr_t ptr_rd_addr,
  output logic  ptr_rd_data_valid,
  output addr_t ptr_rd_data
);

  addr_t mem [`LL_DEPTH];

  always_ff @(posedge clk) begin
    if (ptr_wr_valid) begin
      mem[ptr_wr_addr] <= ptr_wr_data;
    end
  end

  // Read data is captured only on a request and holds otherwise.
  always_ff @(posedge clk) begin
    if (ptr_rd_valid) begin
      ptr_rd_data <= mem[ptr_rd_addr];
    end
  end

  // The valid flag trails the request by exactly one cycle.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr_rd_data_valid <= 1'b0;
    end else begin
      ptr_rd_data_valid <= ptr_rd_valid;
    end
  end

endmodule

// File: src/ll_tail_steer.sv
// Push stage that steers each new address to a list, keeps tails and links the pointer RAM.
`timescale 1ns/1ns
`include "ll_tracker_config.svh"

module ll_tail_steer
  import ll_tracker_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      next_tail_valid,
  input  addr_t     next_tail,
  input  list_sel_t list_empty,
  output logic      push_valid,
  output list_sel_t push_sel,
  output addr_t     push_addr,
  output logic      ptr_wr_valid,
  output addr_t     ptr_wr_addr,
  output addr_t     ptr_wr_data
);

  list_sel_t tail_sel;
  list_sel_t tail_sel_next;
  addr_t     tail_q [`LL_NUM_LISTS];
  logic      tail_list_busy;

  // Rotate the tail selector left by one list.
  always_comb begin
    for (int i = 0; i < `LL_NUM_LISTS; i++) begin
      tail_sel_next[i] = tail_sel[(i + `LL_NUM_LISTS - 1) % `LL_NUM_LISTS];
    end
  end

  // The selector only moves when a push lands, so pushes walk the lists in order.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tail_sel <= list_sel_t'(1);
    end else if (next_tail_valid) begin
      tail_sel <= tail_sel_next;
    end
  end

  // Every push becomes the new tail of the list it was steered to.
  always_ff @(posedge clk) begin
    for (int i = 0; i < `LL_NUM_LISTS; i++) begin
      if (push_sel[i]) begin
        tail_q[i] <= next_tail;
      end
    end
  end

  assign push_valid = next_tail_valid;
  assign push_sel   = tail_sel & {`LL_NUM_LISTS{next_tail_valid}};
  assign push_addr  = next_tail;

  // An empty list has no tail to link from. The new address turns into its
  // head directly in the head stage.
  assign tail_list_busy = |(tail_sel & ~list_empty);
  assign ptr_wr_valid   = next_tail_valid && tail_list_busy;

  // Old tail of the selected list is the RAM slot that receives the link.
  always_comb begin
    ptr_wr_addr = '0;
    for (int i = 0; i < `LL_NUM_LISTS; i++) begin
      ptr_wr_addr = ptr_wr_addr | ({`LL_ADDR_W{tail_sel[i]}} & tail_q[i]);
    end
  end

  assign ptr_wr_data = next_tail;

endmodule

// File: src/ll_tracker_config.svh
// Linked-list tracker configuration: tracker depth, list count and derived widths.
`ifndef LL_TRACKER_CONFIG_SVH
`define LL_TRACKER_CONFIG_SVH

// Number of entries held by the tracker and by the pointer RAM.
`define LL_DEPTH 16

// Number of linked lists the entries are threaded through.
// Must be at least 1 and below the depth.
`define LL_NUM_LISTS 4

// Width of an entry address.
`define LL_ADDR_W ($clog2(`LL_DEPTH))

// Width of an item count, wide enough to hold the full depth.
`define LL_COUNT_W ($clog2(`LL_DEPTH + 1))

`endif

// File: src/ll_tracker_pkg.sv
// Linked-list tracker package with the shared address, count and list-select types.
`include "ll_tracker_config.svh"

package ll_tracker_pkg;

  // Entry address, also used as a pointer RAM index and payload.
  typedef logic [`LL_ADDR_W-1:0] addr_t;

  // Item count for one list or for the whole tracker.
  typedef logic [`LL_COUNT_W-1:0] count_t;

  // One-hot selector over the linked lists.
  typedef logic [`LL_NUM_LISTS-1:0] list_sel_t;

endpackage

// File: src/ll_tracker_top.sv
// Linked-list tracker top level joining the push stage, the pointer RAM and the head stage.
`timescale 1ns/1ns

module ll_tracker_top
  import ll_tracker_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   next_tail_valid,
  input  addr_t  next_tail,
  output logic   head_valid,
  input  logic   head_ready,
  output addr_t  head,
  output logic   empty,
  output count_t items
);

  logic      push_valid;
  list_sel_t push_sel;
  addr_t     push_addr;
  list_sel_t list_empty;
  logic      ptr_wr_valid;
  addr_t     ptr_wr_addr;
  addr_t     ptr_wr_data;
  logic      ptr_rd_valid;
  addr_t     ptr_rd_addr;
  logic      ptr_rd_data_valid;
  addr_t     ptr_rd_data;

  ll_tail_steer u_tail_steer (
    .clk             (clk),
    .arst_n          (arst_n),
    .next_tail_valid (next_tail_valid),
    .next_tail       (next_tail),
    .list_empty      (list_empty),
    .push_valid      (push_valid),
    .push_sel        (push_sel),
    .push_addr       (push_addr),
    .ptr_wr_valid    (ptr_wr_valid),
    .ptr_wr_addr     (ptr_wr_addr),
    .ptr_wr_data     (ptr_wr_data)
  );

  ll_ptr_ram u_ptr_ram (
    .clk               (clk),
    .arst_n            (arst_n),
    .ptr_wr_valid      (ptr_wr_valid),
    .ptr_wr_addr       (ptr_wr_addr),
    .ptr_wr_data       (ptr_wr_data),
    .ptr_rd_valid      (ptr_rd_valid),
    .ptr_rd_addr       (ptr_rd_addr),
    .ptr_rd_data_valid (ptr_rd_data_valid),
    .ptr_rd_data       (ptr_rd_data)
  );

  ll_head_ctrl u_head_ctrl (
    .clk               (clk),
    .arst_n            (arst_n),
    .push_valid        (push_valid),
    .push_sel          (push_sel),
    .push_addr         (push_addr),
    .head_valid        (head_valid),
    .head_ready        (head_ready),
    .head              (head),
    .list_empty        (list_empty),
    .ptr_rd_valid      (ptr_rd_valid),
    .ptr_rd_addr       (ptr_rd_addr),
    .ptr_rd_data_valid (ptr_rd_data_valid),
    .ptr_rd_data       (ptr_rd_data),
    .empty             (empty),
    .items             (items)
  );

endmodule
